// ==== src/core_config.svh ====
/*
 * Core sizing macros: lane, thread and register counts,
 * cache line size and the PC register index
 */

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Lanes per vector register
`define VECTOR_LANES 4

// Hardware threads sharing the register file
`define NUM_THREADS 2

// Registers per bank, per thread
`define NUM_REGS 32

// One 32-bit word per lane
`define CACHE_LINE_BYTES 16

// Writing this register redirects the thread
`define REG_PC 31

`endif

// ==== src/core_pkg.sv ====
/*
 * Shared retire types: register words, vectors, indices,
 * memory operation and pipeline enums, decoded instruction
 */

`default_nettype none

`include "core_config.svh"

package core_pkg;

	typedef logic [31:0] scalar_t;

	// Lane 0 sits in the low bits
	typedef scalar_t [`VECTOR_LANES - 1:0] vector_t;

	typedef logic [`VECTOR_LANES - 1:0] lane_mask_t;

	typedef logic [$clog2(`NUM_THREADS) - 1:0] thread_idx_t;

	typedef logic [4:0] register_idx_t;

	// One subcycle per lane for gathers
	typedef logic [$clog2(`VECTOR_LANES) - 1:0] subcycle_t;

	// Load kinds handled at retire
	typedef enum logic [2:0]
	{
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_BLOCK,
		MEM_GATHER
	} mem_op_t;

	// Which path caused a rollback
	typedef enum logic
	{
		PIPE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

	typedef struct packed
	{
		logic has_dest;
		logic dest_is_vector;
		register_idx_t dest_reg;
		logic is_compare;
		logic is_load;
		logic is_call;
		mem_op_t memory_op;
		subcycle_t last_subcycle;
		scalar_t pc;
	} decoded_instruction_t;

endpackage

`default_nettype wire

// ==== src/writeback_if.sv ====
/*
 * Registered writeback bus from the writeback stage
 * to the lane banks and the register read port
 */

`default_nettype none
`timescale 1ns/100ps

interface writeback_if import core_pkg::*; ();

	logic en;
	thread_idx_t thread;
	logic is_vector;
	register_idx_t dest_reg;
	vector_t value;
	lane_mask_t mask;

	modport stage
	(
		output en,
		output thread,
		output is_vector,
		output dest_reg,
		output value,
		output mask
	);

	modport sink
	(
		input en,
		input thread,
		input is_vector,
		input dest_reg,
		input value,
		input mask
	);

endinterface

`default_nettype wire

// ==== src/load_aligner.sv ====
/*
 * Load data aligner: word select from a cache line, byte and
 * halfword alignment with extension, block byte swap
 */

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module load_aligner import core_pkg::*;
(
	input wire logic [`CACHE_LINE_BYTES * 8 - 1:0] line,
	input scalar_t request_addr,
	input mem_op_t memory_op,
	output scalar_t aligned_value,
	output vector_t block_value
);

	localparam int LINE_WORDS = `CACHE_LINE_BYTES / 4;
	localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

	scalar_t line_word;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;

	// Word 0 is the most significant word of the line
	assign line_word = line[(LINE_WORDS - 1 - request_addr[2+:WORD_IDX_BITS]) * 32+:32];

	always_comb
	begin
		case (request_addr[1:0])
			2'd0: byte_aligned = line_word[31:24];
			2'd1: byte_aligned = line_word[23:16];
			2'd2: byte_aligned = line_word[15:8];
			default: byte_aligned = line_word[7:0];
		endcase
	end

	// Halfword comes out little-endian
	always_comb
	begin
		if (request_addr[1])
			half_aligned = {line_word[7:0], line_word[15:8]};
		else
			half_aligned = {line_word[23:16], line_word[31:24]};
	end

	always_comb
	begin
		case (memory_op)
			MEM_B: aligned_value = {24'd0, byte_aligned};
			MEM_BX: aligned_value = {{24{byte_aligned[7]}}, byte_aligned};
			MEM_S: aligned_value = {16'd0, half_aligned};
			MEM_SX: aligned_value = {{16{half_aligned[15]}}, half_aligned};

			// Word loads and gathers take the full swapped word
			default: aligned_value = {line_word[7:0], line_word[15:8],
				line_word[23:16], line_word[31:24]};
		endcase
	end

	// Every lane of a block load gets its bytes reversed
	genvar word;
	generate
		for (word = 0; word < LINE_WORDS; word++)
		begin : swap
			assign block_value[word] = {line[word * 32+:8], line[word * 32 + 8+:8],
				line[word * 32 + 16+:8], line[word * 32 + 24+:8]};
		end
	endgenerate

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
/*
 * Writeback stage: rollback selection, load result routing,
 * compare collection and the registered writeback
 */

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module writeback_stage import core_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Single-cycle arithmetic path
	input wire logic sx_instruction_valid,
	input decoded_instruction_t sx_instruction,
	input vector_t sx_result,
	input thread_idx_t sx_thread_idx,
	input lane_mask_t sx_mask_value,
	input wire logic sx_rollback_en,
	input scalar_t sx_rollback_pc,
	input subcycle_t sx_subcycle,

	// Multi-cycle arithmetic path
	input wire logic mx_instruction_valid,
	input decoded_instruction_t mx_instruction,
	input vector_t mx_result,
	input thread_idx_t mx_thread_idx,
	input lane_mask_t mx_mask_value,
	input subcycle_t mx_subcycle,

	// Memory path
	input wire logic dd_instruction_valid,
	input decoded_instruction_t dd_instruction,
	input thread_idx_t dd_thread_idx,
	input lane_mask_t dd_mask_value,
	input subcycle_t dd_subcycle,
	input scalar_t dd_request_addr,
	input wire logic [`CACHE_LINE_BYTES * 8 - 1:0] dd_load_line,

	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread_idx,
	output scalar_t wb_rollback_pc,
	output pipeline_sel_t wb_rollback_pipeline,
	output subcycle_t wb_rollback_subcycle,

	writeback_if.stage wb,
	output logic wb_is_last_subcycle
);

	scalar_t aligned_value;
	vector_t block_value;
	lane_mask_t sx_compare_bits;
	lane_mask_t mx_compare_bits;
	lane_mask_t gather_lane;
	logic next_en;
	logic next_is_last;
	thread_idx_t next_thread;
	logic next_is_vector;
	register_idx_t next_reg;
	vector_t next_value;
	lane_mask_t next_mask;

	load_aligner load_aligner_inst
	(
		.line(dd_load_line),
		.request_addr(dd_request_addr),
		.memory_op(dd_instruction.memory_op),
		.aligned_value(aligned_value),
		.block_value(block_value)
	);

	// Not registered, so the following instruction never takes effect
	always_comb
	begin
		wb_rollback_en = 1'b0;
		wb_rollback_thread_idx = '0;
		wb_rollback_pc = '0;
		wb_rollback_pipeline = PIPE_ARITH;
		wb_rollback_subcycle = '0;
		if (sx_instruction_valid && sx_instruction.has_dest
			&& sx_instruction.dest_reg == `REG_PC)
		begin
			wb_rollback_en = 1'b1;
			wb_rollback_thread_idx = sx_thread_idx;
			wb_rollback_pc = sx_result[0];
		end
		else if (dd_instruction_valid && dd_instruction.has_dest
			&& dd_instruction.dest_reg == `REG_PC)
		begin
			wb_rollback_en = 1'b1;
			wb_rollback_thread_idx = dd_thread_idx;
			wb_rollback_pc = aligned_value;
			wb_rollback_pipeline = PIPE_MEM;
		end
		else if (sx_instruction_valid)
		begin
			wb_rollback_en = sx_rollback_en;
			wb_rollback_thread_idx = sx_thread_idx;
			wb_rollback_pc = sx_rollback_pc;
			wb_rollback_subcycle = sx_subcycle;
		end
	end

	// Bit 0 of each lane forms the compare mask
	genvar lane;
	generate
		for (lane = 0; lane < `VECTOR_LANES; lane++)
		begin : collect_compare
			assign sx_compare_bits[lane] = sx_result[lane][0];
			assign mx_compare_bits[lane] = mx_result[lane][0];
		end
	endgenerate

	// Gathers fill lanes from the top down
	assign gather_lane = lane_mask_t'(1) << (`VECTOR_LANES - 1 - dd_subcycle);

	always_comb
	begin
		next_en = 1'b0;
		next_is_last = 1'b0;
		next_thread = '0;
		next_is_vector = 1'b0;
		next_reg = '0;
		next_value = '0;
		next_mask = '0;
		if (mx_instruction_valid)
		begin
			next_en = mx_instruction.has_dest && !wb_rollback_en;
			next_is_last = mx_subcycle == mx_instruction.last_subcycle;
			next_thread = mx_thread_idx;
			next_is_vector = mx_instruction.dest_is_vector;
			next_reg = mx_instruction.dest_reg;
			next_mask = mx_mask_value;
			if (mx_instruction.is_compare)
				next_value[0] = scalar_t'(mx_compare_bits);
			else
				next_value = mx_result;
		end
		else if (sx_instruction_valid)
		begin
			// A call still writes its link register
			next_en = sx_instruction.is_call || (sx_instruction.has_dest && !wb_rollback_en);
			next_is_last = sx_subcycle == sx_instruction.last_subcycle;
			next_thread = sx_thread_idx;
			next_is_vector = sx_instruction.dest_is_vector;
			next_reg = sx_instruction.dest_reg;
			next_mask = sx_mask_value;
			if (sx_instruction.is_compare)
				next_value[0] = scalar_t'(sx_compare_bits);
			else
				next_value = sx_result;
		end
		else if (dd_instruction_valid)
		begin
			next_en = dd_instruction.has_dest && !wb_rollback_en;
			next_is_last = dd_subcycle == dd_instruction.last_subcycle;
			next_thread = dd_thread_idx;
			next_is_vector = dd_instruction.dest_is_vector;
			next_reg = dd_instruction.dest_reg;
			case (dd_instruction.memory_op)
				MEM_BLOCK:
				begin
					next_value = block_value;
					next_mask = dd_mask_value;
				end
				MEM_GATHER:
				begin
					next_value = {`VECTOR_LANES{aligned_value}};
					next_mask = gather_lane & dd_mask_value;
				end
				default:
				begin
					next_value = {`VECTOR_LANES{aligned_value}};
					next_mask = '1;
				end
			endcase
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb.en <= 1'b0;
			wb_is_last_subcycle <= 1'b0;
		end
		else
		begin
			wb.en <= next_en;
			wb_is_last_subcycle <= next_is_last;
		end
	end

	always_ff @(posedge clk)
	begin
		wb.thread <= next_thread;
		wb.is_vector <= next_is_vector;
		wb.dest_reg <= next_reg;
		wb.value <= next_value;
		wb.mask <= next_mask;
	end

	assert property (@(posedge clk) disable iff (reset)
		$onehot0({sx_instruction_valid, mx_instruction_valid, dd_instruction_valid}))
		else $error("more than one retire source valid");

	assert property (@(posedge clk) disable iff (reset)
		dd_instruction_valid && dd_instruction.is_load |-> dd_instruction.has_dest)
		else $error("load without destination");

	assert property (@(posedge clk) disable iff (reset)
		dd_instruction_valid && dd_instruction.is_load
		&& dd_instruction.memory_op inside {MEM_B, MEM_BX, MEM_S, MEM_SX, MEM_L}
		|-> !dd_instruction.dest_is_vector)
		else $error("scalar load into vector register");

	assert property (@(posedge clk) disable iff (reset)
		dd_instruction_valid && dd_instruction.is_load && dd_instruction.memory_op == MEM_BLOCK
		|-> dd_instruction.dest_is_vector)
		else $error("block load into scalar register");

	// A PC load redirects only once all its subcycles are done
	assert property (@(posedge clk) disable iff (reset)
		dd_instruction_valid && dd_instruction.is_load && dd_instruction.has_dest
		&& dd_instruction.dest_reg == `REG_PC
		|-> dd_subcycle == dd_instruction.last_subcycle)
		else $error("PC load before last subcycle");

endmodule

`default_nettype wire

// ==== src/vector_lane_regfile.sv ====
/*
 * One vector lane's register bank for all threads
 */

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module vector_lane_regfile import core_pkg::*;
#(
	parameter int LANE = 0
)
(
	input wire logic clk,
	input wire logic reset,
	writeback_if.sink wb,
	input thread_idx_t read_thread,
	input register_idx_t read_reg,
	output scalar_t read_value
);

	scalar_t regs [`NUM_THREADS][`NUM_REGS];
	logic lane_write;

	// Only vector writes with this lane's mask bit land here
	assign lane_write = wb.en && wb.is_vector && wb.mask[LANE];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			regs <= '{default: '0};
		else if (lane_write)
			regs[wb.thread][wb.dest_reg] <= wb.value[LANE];
	end

	assign read_value = regs[read_thread][read_reg];

	assert property (@(posedge clk) disable iff (reset)
		lane_write |-> !$isunknown(wb.value[LANE]))
		else $error("unknown value written to lane %0d", LANE);

endmodule

`default_nettype wire

// ==== src/register_read_port.sv ====
/*
 * Scalar register bank and the register read mux
 */

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module register_read_port import core_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	writeback_if.sink wb,
	input vector_t lane_values,
	input thread_idx_t read_thread,
	input register_idx_t read_reg,
	input wire logic read_is_vector,
	output vector_t read_value
);

	scalar_t scalar_regs [`NUM_THREADS][`NUM_REGS];

	// Scalar results always come in lane 0
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			scalar_regs <= '{default: '0};
		else if (wb.en && !wb.is_vector)
			scalar_regs[wb.thread][wb.dest_reg] <= wb.value[0];
	end

	// Scalars are broadcast across all lanes
	assign read_value = read_is_vector ? lane_values
		: {`VECTOR_LANES{scalar_regs[read_thread][read_reg]}};

endmodule

`default_nettype wire

// ==== src/retire_top.sv ====
/*
 * Retire top level: writeback stage, per-lane banks, read port
 */

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module retire_top import core_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	input wire logic sx_instruction_valid,
	input decoded_instruction_t sx_instruction,
	input vector_t sx_result,
	input thread_idx_t sx_thread_idx,
	input lane_mask_t sx_mask_value,
	input wire logic sx_rollback_en,
	input scalar_t sx_rollback_pc,
	input subcycle_t sx_subcycle,

	input wire logic mx_instruction_valid,
	input decoded_instruction_t mx_instruction,
	input vector_t mx_result,
	input thread_idx_t mx_thread_idx,
	input lane_mask_t mx_mask_value,
	input subcycle_t mx_subcycle,

	input wire logic dd_instruction_valid,
	input decoded_instruction_t dd_instruction,
	input thread_idx_t dd_thread_idx,
	input lane_mask_t dd_mask_value,
	input subcycle_t dd_subcycle,
	input scalar_t dd_request_addr,
	input wire logic [`CACHE_LINE_BYTES * 8 - 1:0] dd_load_line,

	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread_idx,
	output scalar_t wb_rollback_pc,
	output pipeline_sel_t wb_rollback_pipeline,
	output subcycle_t wb_rollback_subcycle,

	output logic wb_writeback_en,
	output thread_idx_t wb_writeback_thread_idx,
	output logic wb_writeback_is_vector,
	output register_idx_t wb_writeback_reg,
	output logic wb_writeback_is_last_subcycle,

	input thread_idx_t read_thread_idx,
	input register_idx_t read_reg,
	input wire logic read_is_vector,
	output vector_t read_value
);

	writeback_if wb_bus();
	vector_t lane_values;

	writeback_stage writeback_stage_inst
	(
		.clk(clk),
		.reset(reset),
		.sx_instruction_valid(sx_instruction_valid),
		.sx_instruction(sx_instruction),
		.sx_result(sx_result),
		.sx_thread_idx(sx_thread_idx),
		.sx_mask_value(sx_mask_value),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc),
		.sx_subcycle(sx_subcycle),
		.mx_instruction_valid(mx_instruction_valid),
		.mx_instruction(mx_instruction),
		.mx_result(mx_result),
		.mx_thread_idx(mx_thread_idx),
		.mx_mask_value(mx_mask_value),
		.mx_subcycle(mx_subcycle),
		.dd_instruction_valid(dd_instruction_valid),
		.dd_instruction(dd_instruction),
		.dd_thread_idx(dd_thread_idx),
		.dd_mask_value(dd_mask_value),
		.dd_subcycle(dd_subcycle),
		.dd_request_addr(dd_request_addr),
		.dd_load_line(dd_load_line),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.wb_rollback_pc(wb_rollback_pc),
		.wb_rollback_pipeline(wb_rollback_pipeline),
		.wb_rollback_subcycle(wb_rollback_subcycle),
		.wb(wb_bus.stage),
		.wb_is_last_subcycle(wb_writeback_is_last_subcycle)
	);

	// One bank per lane, each picking its own value and mask bit
	genvar lane;
	generate
		for (lane = 0; lane < `VECTOR_LANES; lane++)
		begin : lane_bank
			vector_lane_regfile #(.LANE(lane)) vector_lane_regfile_inst
			(
				.clk(clk),
				.reset(reset),
				.wb(wb_bus.sink),
				.read_thread(read_thread_idx),
				.read_reg(read_reg),
				.read_value(lane_values[lane])
			);
		end
	endgenerate

	register_read_port register_read_port_inst
	(
		.clk(clk),
		.reset(reset),
		.wb(wb_bus.sink),
		.lane_values(lane_values),
		.read_thread(read_thread_idx),
		.read_reg(read_reg),
		.read_is_vector(read_is_vector),
		.read_value(read_value)
	);

	assign wb_writeback_en = wb_bus.en;
	assign wb_writeback_thread_idx = wb_bus.thread;
	assign wb_writeback_is_vector = wb_bus.is_vector;
	assign wb_writeback_reg = wb_bus.dest_reg;

endmodule

`default_nettype wire

// ==== dv/tb_retire.sv ====
/*
 * Retire testbench: clock, reset, LFSR stimulus, shadow register
 * model, checking assertions and watchdog
 */

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module tb_retire import core_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int NUM_OPS = 240;
	localparam int LINE_BITS = `CACHE_LINE_BYTES * 8;

	typedef struct packed
	{
		logic en;
		thread_idx_t thread;
		logic is_vector;
		register_idx_t dest_reg;
		logic is_last;
		vector_t value;
		lane_mask_t mask;
	} write_t;

	logic clk;
	logic reset;
	logic sx_instruction_valid;
	decoded_instruction_t sx_instruction;
	vector_t sx_result;
	thread_idx_t sx_thread_idx;
	lane_mask_t sx_mask_value;
	logic sx_rollback_en;
	scalar_t sx_rollback_pc;
	subcycle_t sx_subcycle;
	logic mx_instruction_valid;
	decoded_instruction_t mx_instruction;
	vector_t mx_result;
	thread_idx_t mx_thread_idx;
	lane_mask_t mx_mask_value;
	subcycle_t mx_subcycle;
	logic dd_instruction_valid;
	decoded_instruction_t dd_instruction;
	thread_idx_t dd_thread_idx;
	lane_mask_t dd_mask_value;
	subcycle_t dd_subcycle;
	scalar_t dd_request_addr;
	logic [LINE_BITS - 1:0] dd_load_line;
	logic wb_rollback_en;
	thread_idx_t wb_rollback_thread_idx;
	scalar_t wb_rollback_pc;
	pipeline_sel_t wb_rollback_pipeline;
	subcycle_t wb_rollback_subcycle;
	logic wb_writeback_en;
	thread_idx_t wb_writeback_thread_idx;
	logic wb_writeback_is_vector;
	register_idx_t wb_writeback_reg;
	logic wb_writeback_is_last_subcycle;
	thread_idx_t read_thread_idx;
	register_idx_t read_reg;
	logic read_is_vector;
	vector_t read_value;

	logic [31:0] lfsr_state;

	// Expected rollback in the same cycle as the inputs
	logic exp_rb_en;
	thread_idx_t exp_rb_thread;
	scalar_t exp_rb_pc;
	pipeline_sel_t exp_rb_pipeline;
	logic exp_rb_passed;

	write_t next_write;
	write_t exp_write;
	scalar_t shadow_vector [`NUM_THREADS][`NUM_REGS][`VECTOR_LANES];
	scalar_t shadow_scalar [`NUM_THREADS][`NUM_REGS];
	vector_t exp_read_value;

	retire_top retire_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		fail_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		int i;
		bits = '0;
		for (i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return bits;
	endfunction

	function automatic vector_t random_vector();
		vector_t v;
		int lane;
		for (lane = 0; lane < `VECTOR_LANES; lane++)
			v[lane] = random_bits(32);
		return v;
	endfunction

	// Byte 0 of the line sits in the top bits
	function automatic logic [7:0] line_byte(input logic [LINE_BITS - 1:0] line,
		input logic [3:0] a);
		return line[(15 - a) * 8+:8];
	endfunction

	function automatic scalar_t line_word_le(input logic [LINE_BITS - 1:0] line,
		input logic [3:0] base);
		return {line_byte(line, base + 4'd3), line_byte(line, base + 4'd2),
			line_byte(line, base + 4'd1), line_byte(line, base)};
	endfunction

	function automatic scalar_t expected_load(input logic [LINE_BITS - 1:0] line,
		input scalar_t addr, input mem_op_t op);
		logic [7:0] b;
		logic [15:0] h;
		b = line_byte(line, addr[3:0]);
		h = {line_byte(line, {addr[3:1], 1'b1}), line_byte(line, {addr[3:1], 1'b0})};
		case (op)
			MEM_B: return {24'd0, b};
			MEM_BX: return {{24{b[7]}}, b};
			MEM_S: return {16'd0, h};
			MEM_SX: return {{16{h[15]}}, h};
			default: return line_word_le(line, {addr[3:2], 2'b00});
		endcase
	endfunction

	// Lane 0 holds the last word of the line
	function automatic vector_t block_value(input logic [LINE_BITS - 1:0] line);
		vector_t v;
		int lane;
		for (lane = 0; lane < `VECTOR_LANES; lane++)
			v[lane] = line_word_le(line, 4'((`VECTOR_LANES - 1 - lane) * 4));
		return v;
	endfunction

	function automatic vector_t compare_value(input vector_t result);
		vector_t v;
		int lane;
		v = '0;
		for (lane = 0; lane < `VECTOR_LANES; lane++)
			v[0][lane] = result[lane][0];
		return v;
	endfunction

	function automatic write_t write_header(input decoded_instruction_t instr,
		input thread_idx_t thread, input subcycle_t subcycle, input logic rollback);
		write_t w;
		w = '0;
		// A call writes its link register even while rolling back
		w.en = instr.is_call || (instr.has_dest && !rollback);
		w.thread = thread;
		w.is_vector = instr.dest_is_vector;
		w.dest_reg = instr.dest_reg;
		w.is_last = subcycle == instr.last_subcycle;
		return w;
	endfunction

	always_comb
	begin
		exp_rb_en = 1'b0;
		exp_rb_thread = '0;
		exp_rb_pc = '0;
		exp_rb_pipeline = PIPE_ARITH;
		exp_rb_passed = 1'b0;
		if (sx_instruction_valid && sx_instruction.has_dest
			&& sx_instruction.dest_reg == `REG_PC)
		begin
			exp_rb_en = 1'b1;
			exp_rb_thread = sx_thread_idx;
			exp_rb_pc = sx_result[0];
		end
		else if (dd_instruction_valid && dd_instruction.has_dest
			&& dd_instruction.dest_reg == `REG_PC)
		begin
			exp_rb_en = 1'b1;
			exp_rb_thread = dd_thread_idx;
			exp_rb_pc = expected_load(dd_load_line, dd_request_addr, dd_instruction.memory_op);
			exp_rb_pipeline = PIPE_MEM;
		end
		else if (sx_instruction_valid)
		begin
			exp_rb_en = sx_rollback_en;
			exp_rb_thread = sx_thread_idx;
			exp_rb_pc = sx_rollback_pc;
			exp_rb_passed = 1'b1;
		end
	end

	always_comb
	begin
		next_write = '0;
		if (sx_instruction_valid)
		begin
			next_write = write_header(sx_instruction, sx_thread_idx, sx_subcycle, exp_rb_en);
			next_write.mask = sx_mask_value;
			next_write.value = sx_instruction.is_compare ? compare_value(sx_result) : sx_result;
		end
		else if (mx_instruction_valid)
		begin
			next_write = write_header(mx_instruction, mx_thread_idx, mx_subcycle, exp_rb_en);
			next_write.mask = mx_mask_value;
			next_write.value = mx_instruction.is_compare ? compare_value(mx_result) : mx_result;
		end
		else if (dd_instruction_valid)
		begin
			next_write = write_header(dd_instruction, dd_thread_idx, dd_subcycle, exp_rb_en);
			next_write.value = {`VECTOR_LANES{expected_load(dd_load_line, dd_request_addr,
				dd_instruction.memory_op)}};
			next_write.mask = '1;
			if (dd_instruction.memory_op == MEM_BLOCK)
			begin
				next_write.value = block_value(dd_load_line);
				next_write.mask = dd_mask_value;
			end
			else if (dd_instruction.memory_op == MEM_GATHER)
			begin
				next_write.mask = '0;
				next_write.mask[`VECTOR_LANES - 1 - dd_subcycle] =
					dd_mask_value[`VECTOR_LANES - 1 - dd_subcycle];
			end
		end
	end

	// Shadow banks take the write one edge after it is registered
	always_ff @(posedge clk, posedge reset)
	begin : shadow_update
		int lane;
		if (reset)
		begin
			exp_write <= '0;
			shadow_vector <= '{default: '0};
			shadow_scalar <= '{default: '0};
		end
		else
		begin
			exp_write <= next_write;
			if (exp_write.en && exp_write.is_vector)
			begin
				for (lane = 0; lane < `VECTOR_LANES; lane++)
					if (exp_write.mask[lane])
						shadow_vector[exp_write.thread][exp_write.dest_reg][lane] <=
							exp_write.value[lane];
			end
			else if (exp_write.en)
				shadow_scalar[exp_write.thread][exp_write.dest_reg] <= exp_write.value[0];
		end
	end

	always_comb
	begin : read_model
		int lane;
		for (lane = 0; lane < `VECTOR_LANES; lane++)
			exp_read_value[lane] = read_is_vector ? shadow_vector[read_thread_idx][read_reg][lane]
				: shadow_scalar[read_thread_idx][read_reg];
	end

	assert property (@(posedge clk) $fell(reset) |-> !wb_writeback_en && !wb_rollback_en)
		else fail_run("write or rollback enable active right after reset");
	assert property (@(posedge clk) disable iff (reset) wb_rollback_en == exp_rb_en)
		else report_mismatch("wb_rollback_en", $sampled(wb_rollback_en), $sampled(exp_rb_en));
	assert property (@(posedge clk) disable iff (reset)
		exp_rb_en |-> wb_rollback_pc == exp_rb_pc)
		else report_mismatch("wb_rollback_pc", $sampled(wb_rollback_pc), $sampled(exp_rb_pc));
	assert property (@(posedge clk) disable iff (reset)
		exp_rb_en |-> wb_rollback_thread_idx == exp_rb_thread)
		else report_mismatch("wb_rollback_thread_idx", $sampled(wb_rollback_thread_idx),
			$sampled(exp_rb_thread));
	assert property (@(posedge clk) disable iff (reset)
		exp_rb_en |-> wb_rollback_pipeline == exp_rb_pipeline)
		else report_mismatch("wb_rollback_pipeline", $sampled(wb_rollback_pipeline),
			$sampled(exp_rb_pipeline));
	assert property (@(posedge clk) disable iff (reset)
		exp_rb_en && exp_rb_passed |-> wb_rollback_subcycle == sx_subcycle)
		else report_mismatch("wb_rollback_subcycle", $sampled(wb_rollback_subcycle),
			$sampled(sx_subcycle));
	assert property (@(posedge clk) disable iff (reset) wb_writeback_en == exp_write.en)
		else report_mismatch("wb_writeback_en", $sampled(wb_writeback_en),
			$sampled(exp_write.en));
	assert property (@(posedge clk) disable iff (reset)
		exp_write.en |-> wb_writeback_thread_idx == exp_write.thread)
		else report_mismatch("wb_writeback_thread_idx", $sampled(wb_writeback_thread_idx),
			$sampled(exp_write.thread));
	assert property (@(posedge clk) disable iff (reset)
		exp_write.en |-> wb_writeback_is_vector == exp_write.is_vector)
		else report_mismatch("wb_writeback_is_vector", $sampled(wb_writeback_is_vector),
			$sampled(exp_write.is_vector));
	assert property (@(posedge clk) disable iff (reset)
		exp_write.en |-> wb_writeback_reg == exp_write.dest_reg)
		else report_mismatch("wb_writeback_reg", $sampled(wb_writeback_reg),
			$sampled(exp_write.dest_reg));
	assert property (@(posedge clk) disable iff (reset)
		wb_writeback_is_last_subcycle == exp_write.is_last)
		else report_mismatch("wb_writeback_is_last_subcycle",
			$sampled(wb_writeback_is_last_subcycle), $sampled(exp_write.is_last));
	assert property (@(posedge clk) disable iff (reset) read_value == exp_read_value)
		else report_mismatch("read_value", $sampled(read_value), $sampled(exp_read_value));

	task automatic clear_inputs();
		sx_instruction_valid = 1'b0;
		sx_instruction = '0;
		sx_result = '0;
		sx_thread_idx = '0;
		sx_mask_value = '0;
		sx_rollback_en = 1'b0;
		sx_rollback_pc = '0;
		sx_subcycle = '0;
		mx_instruction_valid = 1'b0;
		mx_instruction = '0;
		mx_result = '0;
		mx_thread_idx = '0;
		mx_mask_value = '0;
		mx_subcycle = '0;
		dd_instruction_valid = 1'b0;
		dd_instruction = '0;
		dd_thread_idx = '0;
		dd_mask_value = '0;
		dd_subcycle = '0;
		dd_request_addr = '0;
		dd_load_line = '0;
		read_thread_idx = '0;
		read_reg = '0;
		read_is_vector = 1'b0;
	endtask

	function automatic decoded_instruction_t random_instruction();
		decoded_instruction_t instr;
		instr = '0;
		instr.has_dest = 1'b1;
		instr.dest_is_vector = 1'(random_bits(1));
		// Few registers, so masked writes land on older values
		instr.dest_reg = register_idx_t'(random_bits(3));
		instr.memory_op = MEM_L;
		instr.last_subcycle = subcycle_t'(random_bits($bits(subcycle_t)));
		instr.pc = random_bits(32);
		return instr;
	endfunction

	task automatic drive_sx(input decoded_instruction_t instr, input thread_idx_t thread,
		input logic rollback);
		sx_instruction_valid = 1'b1;
		sx_instruction = instr;
		sx_result = random_vector();
		sx_thread_idx = thread;
		sx_mask_value = lane_mask_t'(random_bits(`VECTOR_LANES));
		sx_subcycle = subcycle_t'(random_bits($bits(subcycle_t)));
		sx_rollback_en = rollback;
		sx_rollback_pc = random_bits(32);
	endtask

	task automatic drive_mx(input decoded_instruction_t instr, input thread_idx_t thread);
		mx_instruction_valid = 1'b1;
		mx_instruction = instr;
		mx_result = random_vector();
		mx_thread_idx = thread;
		mx_mask_value = lane_mask_t'(random_bits(`VECTOR_LANES));
		mx_subcycle = subcycle_t'(random_bits($bits(subcycle_t)));
	endtask

	task automatic drive_dd(input decoded_instruction_t instr, input thread_idx_t thread);
		dd_instruction_valid = 1'b1;
		dd_instruction = instr;
		dd_thread_idx = thread;
		dd_mask_value = lane_mask_t'(random_bits(`VECTOR_LANES));
		dd_subcycle = subcycle_t'(random_bits($bits(subcycle_t)));
		dd_request_addr = random_bits(32);
		dd_load_line = random_vector();
	endtask

	// Issue one instruction, then hold the read address until the write shows
	task automatic run_operation();
		logic [2:0] kind;
		decoded_instruction_t instr;
		thread_idx_t thread;
		kind = 3'(random_bits(3));
		instr = random_instruction();
		thread = thread_idx_t'(random_bits($bits(thread_idx_t)));
		@(posedge clk);
		#1;
		case (kind)
			3'd0:
				drive_sx(instr, thread, 1'b0);
			3'd1:
				drive_mx(instr, thread);
			3'd2:
			begin
				instr.is_compare = 1'b1;
				if (random_bits(1))
					drive_sx(instr, thread, 1'b0);
				else
					drive_mx(instr, thread);
			end
			3'd5:
			begin
				instr.dest_reg = `REG_PC;
				drive_sx(instr, thread, 1'b0);
			end
			3'd6:
			begin
				// PC loads are scalar and retire on their last subcycle
				instr.is_load = 1'b1;
				instr.dest_reg = `REG_PC;
				instr.dest_is_vector = 1'b0;
				instr.memory_op = mem_op_t'(random_bits(3) % 5);
				drive_dd(instr, thread);
				dd_subcycle = instr.last_subcycle;
			end
			3'd7:
			begin
				instr.is_call = 1'(random_bits(1));
				drive_sx(instr, thread, 1'(random_bits(1)));
			end
			default:
			begin
				instr.is_load = 1'b1;
				instr.memory_op = mem_op_t'(random_bits(3) % 7);
				instr.dest_is_vector = instr.memory_op inside {MEM_BLOCK, MEM_GATHER};
				drive_dd(instr, thread);
			end
		endcase
		read_thread_idx = thread;
		read_reg = instr.dest_reg;
		read_is_vector = instr.dest_is_vector;
		@(posedge clk);
		#1;
		sx_instruction_valid = 1'b0;
		mx_instruction_valid = 1'b0;
		dd_instruction_valid = 1'b0;
		@(posedge clk);
	endtask

	initial
	begin
		lfsr_state = 32'hae6e_9cff;
		reset = 1'b1;
		clear_inputs();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (NUM_OPS) run_operation();
		@(posedge clk);
		@(posedge clk);
		$display(">>> PASS");
		$finish;
	end

	// Each operation takes three cycles
	initial
	begin
		#(CLK_PERIOD * (NUM_OPS * 4 + 20));
		fail_run("Timeout: the operation sequence did not finish in time");
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/core_pkg.sv
src/writeback_if.sv
src/load_aligner.sv
src/writeback_stage.sv
src/vector_lane_regfile.sv
src/register_read_port.sv
src/retire_top.sv
dv/tb_retire.sv
